/* all.f */
+incdir+dv
common/h80_pkg.sv
common/h80_rf_if.sv
exec/h80_alu.sv
exec/h80_sequencer.sv
hdl/h80_regfile.sv
hdl/h80_core.sv
dv/h80_tb.sv

/* common/h80_pkg.sv */
package h80_pkg;

   // widths
   localparam int word_w = 16;
   localparam int flag_w = 4;

   typedef logic [word_w-1:0] word_t;
   typedef logic [3:0]        reg_num_t;
   typedef logic [flag_w-1:0] flags_t;

   // special registers
   localparam reg_num_t reg_flag = 4'd14;
   localparam reg_num_t reg_pc   = 4'd15;

   // bit positions in the flag register
   localparam int flag_zero     = 0;
   localparam int flag_carry    = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;

   localparam word_t pc_step = 16'd2;   // one instruction word

   // three-register ops, value is the opcode nibble
   typedef enum logic [3:0] {
      alu_add = 4'h8,
      alu_sub = 4'h9,
      alu_and = 4'hc,
      alu_or  = 4'hd,
      alu_xor = 4'he,
      alu_cp  = 4'hf
   } alu_op_t;

   // opcode nibbles
   localparam logic [3:0] op_ctl   = 4'h0;
   localparam logic [3:0] op_ld_lo = 4'h1;
   localparam logic [3:0] op_ld_hi = 4'h2;
   localparam logic [3:0] op_mem   = 4'h3;

   // command field of the 0x3 format
   localparam logic [2:0] cmd_write_w = 3'b000;
   localparam logic [2:0] cmd_read_w  = 3'b001;
   localparam logic [2:0] cmd_mov_ab  = 3'b110;   // reg[b] = reg[a]
   localparam logic [2:0] cmd_mov_ba  = 3'b111;   // reg[a] = reg[b]

   // control group, opcode nibble 0
   localparam word_t      ins_halt  = 16'h0001;
   localparam logic [7:0] ctl_jp_r  = 8'h01;
   localparam logic [3:0] sel_jp_r  = 4'he;       // 0x01er
   localparam logic [7:0] ctl_jp_f  = 8'h03;      // 0x030x..0x037x

   // one instruction word, several field layouts
   typedef union packed {
      struct packed {
         logic [3:0] op;
         reg_num_t   d;
         reg_num_t   a;
         reg_num_t   b;
      } rrr;
      struct packed {
         logic [3:0] op;
         reg_num_t   d;
         logic [7:0] imm;
      } imm;
      struct packed {
         logic [3:0] op;
         logic [2:0] cmd;
         logic       io;
         reg_num_t   a;
         reg_num_t   b;
      } mem;
      struct packed {
         logic [7:0] hi;
         logic       mode;   // 1 selects the relative forms
         logic       pol;    // 1 jumps on flag true
         logic [1:0] fsel;
         reg_num_t   r;
      } ctl;
   } ins_u;

endpackage

/* common/h80_rf_if.sv */
`timescale 1ns/1ps

interface h80_rf_if;

   h80_pkg::reg_num_t rd_a;
   h80_pkg::reg_num_t rd_b;
   logic              wr_en;
   h80_pkg::reg_num_t wr_num;
   h80_pkg::word_t    wr_data;
   logic              flag_en;
   h80_pkg::flags_t   flag_data;
   logic              pc_en;
   h80_pkg::word_t    pc_data;
   h80_pkg::word_t    a_data;
   h80_pkg::word_t    b_data;
   h80_pkg::word_t    pc;
   h80_pkg::flags_t   flags;

   modport seq (output rd_a, rd_b, wr_en, wr_num, wr_data, flag_en, flag_data,
                       pc_en, pc_data,
                input  a_data, b_data, pc, flags);

   modport rf  (input  rd_a, rd_b, wr_en, wr_num, wr_data, flag_en, flag_data,
                       pc_en, pc_data,
                output a_data, b_data, pc, flags);

endinterface

/* dv/h80_model.svh */
function automatic void run_model(input logic [15:0] img [0:1023],
                                  output logic [32:0] xfers [$]);   // {we, addr, wdata}
   logic [15:0] m [0:1023];
   logic [15:0] r [0:15];
   logic [15:0] ins, pc, nxt, av, bv, res, wd;
   logic [16:0] w;
   logic [3:0]  op, d, a, b, wn, fl;
   logic        we, fe;
   m = img;
   for (int i = 0; i < 16; i++) r[i] = 16'h0;
   xfers.delete();
   for (int step = 0; step < 1000; step++) begin
      pc = r[15];
      xfers.push_back({1'b0, pc, 16'h0});   // fetch with wdata 0
      ins = m[pc[10:1]];
      {op, d, a, b} = ins;
      av = r[a];
      bv = r[b];
      nxt = pc + 16'd2;
      we = 1'b0;
      fe = 1'b0;
      wn = d;
      wd = 16'h0;
      w = 17'h0;
      case (op)
         4'h0: begin
            if (ins == 16'h0001) return;   // halt
            if (ins[15:4] == 12'h01e) nxt = bv;
            else if (ins[15:8] == 8'h03 && !ins[7] && r[14][ins[5:4]] == ins[6]) nxt = bv;
         end
         4'h1: begin
            we = 1'b1;
            wd = {r[d][15:8], ins[7:0]};
         end
         4'h2: begin
            we = 1'b1;
            wd = {ins[7:0], r[d][7:0]};
         end
         4'h3: begin
            if (ins[11:8] == 4'h0) begin
               xfers.push_back({1'b1, bv, av});   // store word
               m[bv[10:1]] = av;
            end else if (ins[11:8] == 4'h2) begin
               xfers.push_back({1'b0, bv, 16'h0});   // load word
               we = 1'b1;
               wn = a;
               wd = m[bv[10:1]];
            end else if (ins[11:9] == 3'b110) begin
               we = 1'b1;
               wn = b;
               wd = av;
            end else if (ins[11:9] == 3'b111) begin
               we = 1'b1;
               wn = a;
               wd = bv;
            end
         end
         4'h8, 4'h9, 4'hc, 4'hd, 4'he, 4'hf: begin
            case (op)
               4'h8: w = {1'b0, av} + {1'b0, bv};
               4'h9, 4'hf: w = {1'b0, av} - {1'b0, bv};
               4'hc: w = {1'b0, av & bv};
               4'hd: w = {1'b0, av | bv};
               default: w = {1'b0, av ^ bv};
            endcase
            res = w[15:0];
            fl[0] = (res == 16'h0);
            fl[2] = res[15];
            fl[1] = (op == 4'h8 || op == 4'h9 || op == 4'hf) ? w[16] : 1'b0;
            if (op == 4'h8)
               fl[3] = (av[15] == bv[15]) && (res[15] != av[15]);
            else if (op == 4'h9 || op == 4'hf)
               fl[3] = (av[15] != bv[15]) && (res[15] != av[15]);
            else
               fl[3] = ~^res;   // even parity
            fe = 1'b1;
            we = (op != 4'hf);
            wd = res;
         end
         default: ;
      endcase
      if (we && wn == 4'hf) nxt = wd;
      else if (we) r[wn] = wd;
      if (fe) r[14][3:0] = fl;
      r[15] = nxt;
   end
endfunction

/* dv/h80_tb.sv */
`timescale 1ns/1ps

module h80_tb;

   localparam int ins_budget = 300;   // bound on executed instructions, all tests
   localparam int n_tests    = 5;

   logic clk, reset, mem_req, mem_we, mem_ready, halted;
   logic [15:0] mem_addr, mem_wdata, mem_rdata;
   logic [15:0] mem [0:1023];
   logic [15:0] prog [$];
   logic [32:0] seen [$];   // completed transfers
   int errors = 0;
   int tests = 0;
   int waits = 0;

   `include "h80_model.svh"

   h80_core u_h80_core (.clk(clk), .reset(reset), .mem_req(mem_req), .mem_we(mem_we),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
      .mem_ready(mem_ready), .halted(halted));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // memory with 0 to 3 wait states per request
   initial begin
      forever begin
         @(negedge clk);
         if (mem_ready) begin
            mem_ready = 1'b0;
            waits = int'($urandom % 4);
         end else if (!reset && mem_req) begin
            if (waits == 0) begin
               if (mem_we) mem[mem_addr[10:1]] = mem_wdata;
               else mem_rdata = mem[mem_addr[10:1]];
               mem_ready = 1'b1;
            end else waits--;
         end
      end
   end

   always @(posedge clk)
      if (!reset && mem_req && mem_ready)
         seen.push_back({mem_we, mem_addr, mem_we ? mem_wdata : 16'h0});

   initial begin
      #((ins_budget * 4 * 4 * 4 * 2 + n_tests * 80 * 4) * 1ns);
      $display("timeout: the program did not reach halt in time");
      $display("CHECKS FAILED");
      $finish;
   end

   task automatic compare(input string name, input logic [32:0] got, input logic [32:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic emit(input logic [15:0] w);
      prog.push_back(w);
   endtask

   task automatic load_imm(input logic [3:0] d, input logic [15:0] v);
      emit({4'h1, d, v[7:0]});
      emit({4'h2, d, v[15:8]});
   endtask

   task automatic init_regs();
      prog.delete();
      load_imm(4'h1, 16'h7fff);
      load_imm(4'h2, 16'h0001);
      load_imm(4'h3, 16'h8000);
      load_imm(4'h4, 16'hffff);
      load_imm(4'hc, 16'h0002);   // store pointer step
      load_imm(4'hd, 16'h0400);   // store pointer
   endtask

   // result and flags both end up in memory
   task automatic alu_case(input logic [3:0] op, input logic [3:0] a, input logic [3:0] b);
      emit({op, 4'h6, a, b});
      emit(16'h3e5e);
      emit(16'h306d);
      emit(16'h8ddc);
      emit(16'h305d);
      emit(16'h8ddc);
   endtask

   task automatic branch_case(input logic [3:0] a, input logic [3:0] b, input logic [1:0] f,
                              input logic pol, input logic [7:0] k);
      logic [15:0] target;
      target = 16'((prog.size() + 8) * 2);
      emit({8'hf0, a, b});
      load_imm(4'ha, target);
      emit({8'h03, 1'b0, pol, f, 4'ha});
      load_imm(4'h7, {8'ha0, k});   // fall-through path
      emit(16'h307d);
      emit(16'h8ddc);
      load_imm(4'h7, {8'hb0, k});   // target path
      emit(16'h307d);
      emit(16'h8ddc);
   endtask

   task automatic run_test(input string name);
      logic [32:0] expect_q [$];
      int errs_before;
      int n;
      errs_before = errors;
      reset = 1'b1;
      for (int i = 0; i < 1024; i++) mem[i] = 16'(i * 40503 + 7);
      foreach (prog[i]) mem[i] = prog[i];
      run_model(mem, expect_q);
      repeat (10) @(negedge clk);
      seen.delete();
      reset = 1'b0;
      @(negedge clk);
      compare("first request", {29'h0, mem_req, mem_we, halted, 1'b0}, {29'h0, 4'b1000});
      compare("mem_addr", {17'h0, mem_addr}, 33'h0);
      wait (halted === 1'b1);
      n = seen.size();
      repeat (50) @(negedge clk);
      compare("mem_req after halt", {32'h0, mem_req}, 33'h0);
      compare("transfers after halt", 33'(seen.size()), 33'(n));
      compare("transfer count", 33'(seen.size()), 33'(expect_q.size()));
      for (int i = 0; i < seen.size() && i < expect_q.size(); i++)
         compare($sformatf("transfer %0d", i), seen[i], expect_q[i]);
      tests++;
      $display("test %s finished, %0d errors", name, errors - errs_before);
   endtask

   initial begin
      logic [15:0] t;
      void'($urandom(32'hed91));
      reset = 1'b1;
      mem_ready = 1'b0;
      mem_rdata = 16'h0;
      waits = int'($urandom % 4);

      init_regs();
      alu_case(4'h8, 4'h1, 4'h2);
      alu_case(4'h8, 4'h4, 4'h4);
      alu_case(4'h8, 4'h3, 4'h3);
      alu_case(4'h9, 4'h2, 4'h3);
      alu_case(4'h9, 4'h1, 4'h1);
      alu_case(4'h9, 4'h3, 4'h2);
      alu_case(4'hc, 4'h1, 4'h3);
      alu_case(4'hd, 4'h2, 4'h3);
      alu_case(4'he, 4'h4, 4'h1);
      alu_case(4'he, 4'h2, 4'h2);
      emit(16'h0001);
      run_test("alu");

      init_regs();
      for (int f = 0; f < 4; f++) begin
         branch_case(4'h1, 4'h1, 2'(f), 1'b1, 8'(f * 2));
         branch_case(4'h2, 4'h4, 2'(f), 1'b0, 8'(f * 2 + 1));
         branch_case(4'h3, 4'h2, 2'(f), 1'b1, 8'(f * 2 + 16));
      end
      emit(16'h0001);
      run_test("branch");

      init_regs();
      load_imm(4'h5, 16'h0402);
      load_imm(4'h8, 16'h0410);
      load_imm(4'h9, 16'h0600);
      emit(16'h301d);
      emit(16'h3025);
      emit(16'h326d);
      emit(16'h3275);
      emit(16'h3068);
      emit(16'h888c);
      emit(16'h3078);
      emit(16'h888c);
      emit(16'h32b9);   // fill pattern word
      emit(16'h30b8);
      emit(16'h32ed);   // load into the flag register
      emit(16'h3e5e);
      emit(16'h3058);
      emit(16'h0001);
      run_test("memory");

      prog.delete();
      load_imm(4'h7, 16'h1234);
      t = 16'((prog.size() + 4) * 2);
      load_imm(4'ha, t);
      emit(16'h01ea);
      emit(16'h17ee);   // skipped
      t = 16'((prog.size() + 4) * 2);
      load_imm(4'hb, t);
      emit(16'h3cbf);   // move into pc
      emit(16'h17ee);
      t = 16'((prog.size() + 7) * 2);
      load_imm(4'hc, t);
      load_imm(4'hd, 16'h0400);
      emit(16'h30cd);
      emit(16'h32fd);   // load into pc
      emit(16'h17ee);
      emit(16'h307d);
      emit(16'h0001);
      run_test("jump");

      init_regs();
      emit(16'h0002);
      emit(16'h3a00);
      emit(16'h4123);
      emit(16'h03c5);
      emit(16'h301d);
      emit(16'h0001);
      run_test("halt");

      $display("tests run %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* exec/h80_alu.sv */
`timescale 1ns/1ps

module h80_alu (
   input  h80_pkg::alu_op_t op,
   input  h80_pkg::word_t   a,
   input  h80_pkg::word_t   b,
   output h80_pkg::word_t   result,
   output h80_pkg::flags_t  flags
);

   localparam int msb = h80_pkg::word_w - 1;

   logic [h80_pkg::word_w:0] wide;   // carry or borrow in the top bit
   logic                     carry;
   logic                     overflow;

   always_comb begin
      case (op)
         h80_pkg::alu_add: wide = {1'b0, a} + {1'b0, b};
         h80_pkg::alu_sub,
         h80_pkg::alu_cp:  wide = {1'b0, a} - {1'b0, b};
         h80_pkg::alu_and: wide = {1'b0, a & b};
         h80_pkg::alu_or:  wide = {1'b0, a | b};
         h80_pkg::alu_xor: wide = {1'b0, a ^ b};
         default:          wide = '0;
      endcase
   end

   assign result = wide[msb:0];

   always_comb begin
      case (op)
         h80_pkg::alu_add: begin
            carry    = wide[h80_pkg::word_w];
            overflow = (a[msb] == b[msb]) && (result[msb] != a[msb]);
         end
         h80_pkg::alu_sub,
         h80_pkg::alu_cp: begin
            carry    = wide[h80_pkg::word_w];   // borrow
            overflow = (a[msb] != b[msb]) && (result[msb] != a[msb]);
         end
         default: begin
            // logic ops report even parity in the overflow bit
            carry    = 1'b0;
            overflow = ~^result;
         end
      endcase
   end

   always_comb begin
      flags                         = '0;
      flags[h80_pkg::flag_zero]     = (result == '0);
      flags[h80_pkg::flag_carry]    = carry;
      flags[h80_pkg::flag_sign]     = result[msb];
      flags[h80_pkg::flag_overflow] = overflow;
   end

endmodule

/* exec/h80_sequencer.sv */
`timescale 1ns/1ps

module h80_sequencer (
   input  logic             clk,
   input  logic             reset,
   h80_rf_if.seq            rf,
   output h80_pkg::alu_op_t alu_op,
   output h80_pkg::word_t   alu_a,
   output h80_pkg::word_t   alu_b,
   input  h80_pkg::word_t   alu_result,
   input  h80_pkg::flags_t  alu_flags,
   output logic             mem_req,
   output logic             mem_we,
   output h80_pkg::word_t   mem_addr,
   output h80_pkg::word_t   mem_wdata,
   input  h80_pkg::word_t   mem_rdata,
   input  logic             mem_ready,
   output logic             halted
);

   typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_halt} state_t;

   state_t            state;
   h80_pkg::ins_u     ins_q;      // instruction being executed
   logic              dec_wr_en;
   h80_pkg::reg_num_t dec_wr_num;
   h80_pkg::word_t    dec_wr_data;
   logic              dec_flag_en;
   logic              jump;
   logic              mem_op;
   logic              mem_write;
   logic              halt_op;
   h80_pkg::word_t    next_pc;
   logic              load_done;

   assign load_done = (state == st_mem) && mem_ready && !mem_we;

   // decode of the latched word
   always_comb begin
      rf.rd_a     = ins_q.rrr.a;
      rf.rd_b     = ins_q.rrr.b;   // also mem.b and ctl.r
      alu_op      = h80_pkg::alu_op_t'(ins_q.rrr.op);
      alu_a       = rf.a_data;
      alu_b       = rf.b_data;
      dec_wr_en   = 1'b0;
      dec_wr_num  = ins_q.rrr.d;
      dec_wr_data = alu_result;
      dec_flag_en = 1'b0;
      jump        = 1'b0;
      mem_op      = 1'b0;
      mem_write   = (ins_q.mem.cmd == h80_pkg::cmd_write_w);
      halt_op     = 1'b0;
      case (ins_q.rrr.op)
         h80_pkg::op_ctl: begin
            if (ins_q == h80_pkg::ins_halt)
               halt_op = 1'b1;
            else if (ins_q.ctl.hi == h80_pkg::ctl_jp_r &&
                     {ins_q.ctl.mode, ins_q.ctl.pol, ins_q.ctl.fsel} == h80_pkg::sel_jp_r)
               jump = 1'b1;
            else if (ins_q.ctl.hi == h80_pkg::ctl_jp_f && !ins_q.ctl.mode)
               jump = (rf.flags[ins_q.ctl.fsel] == ins_q.ctl.pol);   // jp f / jpn f
         end
         h80_pkg::op_ld_lo: begin
            rf.rd_a     = ins_q.imm.d;
            dec_wr_en   = 1'b1;
            dec_wr_num  = ins_q.imm.d;
            dec_wr_data = {rf.a_data[15:8], ins_q.imm.imm};
         end
         h80_pkg::op_ld_hi: begin
            rf.rd_a     = ins_q.imm.d;
            dec_wr_en   = 1'b1;
            dec_wr_num  = ins_q.imm.d;
            dec_wr_data = {ins_q.imm.imm, rf.a_data[7:0]};
         end
         h80_pkg::op_mem: begin
            case (ins_q.mem.cmd)
               h80_pkg::cmd_read_w,
               h80_pkg::cmd_write_w: mem_op = !ins_q.mem.io;   // io space is gone
               h80_pkg::cmd_mov_ab: begin
                  dec_wr_en   = 1'b1;
                  dec_wr_num  = ins_q.mem.b;
                  dec_wr_data = rf.a_data;
               end
               h80_pkg::cmd_mov_ba: begin
                  dec_wr_en   = 1'b1;
                  dec_wr_num  = ins_q.mem.a;
                  dec_wr_data = rf.b_data;
               end
               default: ;
            endcase
         end
         h80_pkg::alu_add, h80_pkg::alu_sub, h80_pkg::alu_and,
         h80_pkg::alu_or, h80_pkg::alu_xor: begin
            dec_wr_en   = 1'b1;
            dec_flag_en = 1'b1;
         end
         h80_pkg::alu_cp: dec_flag_en = 1'b1;   // flags only
         default: ;                             // everything else is a nop
      endcase
      next_pc = rf.pc + h80_pkg::pc_step;
      if (jump)
         next_pc = rf.b_data;
      if (dec_wr_en && dec_wr_num == h80_pkg::reg_pc)
         next_pc = dec_wr_data;   // a write to r15 is a jump
   end

   // register file writes happen only in execute or at load completion
   always_comb begin
      rf.wr_en     = 1'b0;
      rf.wr_num    = dec_wr_num;
      rf.wr_data   = dec_wr_data;
      rf.flag_en   = 1'b0;
      rf.flag_data = alu_flags;
      rf.pc_en     = 1'b0;
      rf.pc_data   = next_pc;
      if (state == st_exec) begin
         rf.wr_en   = dec_wr_en;
         rf.flag_en = dec_flag_en;
         rf.pc_en   = 1'b1;
      end else if (load_done) begin
         rf.wr_en   = 1'b1;
         rf.wr_num  = ins_q.mem.a;   // r15 lands through the general write
         rf.wr_data = mem_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_fetch;
         mem_req <= 1'b0;
         mem_we  <= 1'b0;
         halted  <= 1'b0;
      end else begin
         case (state)
            st_fetch: begin
               if (!mem_req) begin
                  mem_req <= 1'b1;   // first fetch after reset
                  mem_we  <= 1'b0;
               end else if (mem_ready) begin
                  mem_req <= 1'b0;
                  state   <= st_exec;
               end
            end
            st_exec: begin
               if (halt_op) begin
                  halted <= 1'b1;
                  state  <= st_halt;
               end else begin
                  mem_req <= 1'b1;
                  mem_we  <= mem_op && mem_write;
                  state   <= mem_op ? st_mem : st_fetch;
               end
            end
            st_mem: begin
               if (mem_ready) begin
                  mem_req <= 1'b1;   // straight into the next fetch
                  mem_we  <= 1'b0;
                  state   <= st_fetch;
               end
            end
            default: ;   // stays halted until reset
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         st_fetch: begin
            if (!mem_req)
               mem_addr <= rf.pc;
            else if (mem_ready)
               ins_q <= h80_pkg::ins_u'(mem_rdata);
         end
         st_exec: begin
            if (mem_op) begin
               mem_addr  <= rf.b_data;
               mem_wdata <= rf.a_data;
            end else begin
               mem_addr <= next_pc;
            end
         end
         st_mem: begin
            if (mem_ready)
               mem_addr <= (load_done && ins_q.mem.a == h80_pkg::reg_pc) ? mem_rdata : rf.pc;
         end
         default: ;
      endcase
   end

endmodule

/* hdl/h80_core.sv */
`timescale 1ns/1ps

module h80_core (
   input  logic           clk,
   input  logic           reset,
   output logic           mem_req,
   output logic           mem_we,
   output h80_pkg::word_t mem_addr,
   output h80_pkg::word_t mem_wdata,
   input  h80_pkg::word_t mem_rdata,
   input  logic           mem_ready,
   output logic           halted
);

   h80_pkg::alu_op_t alu_op;
   h80_pkg::word_t   alu_a;
   h80_pkg::word_t   alu_b;
   h80_pkg::word_t   alu_result;
   h80_pkg::flags_t  alu_flags;

   h80_rf_if rf_bus ();

   h80_sequencer u_sequencer (
      .clk        (clk),
      .reset      (reset),
      .rf         (rf_bus.seq),
      .alu_op     (alu_op),
      .alu_a      (alu_a),
      .alu_b      (alu_b),
      .alu_result (alu_result),
      .alu_flags  (alu_flags),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready),
      .halted     (halted)
   );

   h80_alu u_alu (
      .op     (alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_result),
      .flags  (alu_flags)
   );

   h80_regfile u_regfile (
      .clk   (clk),
      .reset (reset),
      .rf    (rf_bus.rf)
   );

endmodule

/* hdl/h80_regfile.sv */
`timescale 1ns/1ps

module h80_regfile (
   input  logic  clk,
   input  logic  reset,
   h80_rf_if.rf  rf
);

   h80_pkg::word_t gpr [h80_pkg::reg_flag];   // r0..r13
   h80_pkg::word_t flag_q;
   h80_pkg::word_t pc_q;

   assign rf.a_data = (rf.rd_a == h80_pkg::reg_pc)   ? pc_q   :
                      (rf.rd_a == h80_pkg::reg_flag) ? flag_q : gpr[rf.rd_a];
   assign rf.b_data = (rf.rd_b == h80_pkg::reg_pc)   ? pc_q   :
                      (rf.rd_b == h80_pkg::reg_flag) ? flag_q : gpr[rf.rd_b];
   assign rf.pc     = pc_q;
   assign rf.flags  = flag_q[h80_pkg::flag_w-1:0];

   always_ff @(posedge clk) begin
      if (rf.wr_en && rf.wr_num < h80_pkg::reg_flag)
         gpr[rf.wr_num] <= rf.wr_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q   <= '0;
         flag_q <= '0;
      end else begin
         if (rf.pc_en)
            pc_q <= rf.pc_data;   // jump path wins
         else if (rf.wr_en && rf.wr_num == h80_pkg::reg_pc)
            pc_q <= rf.wr_data;
         if (rf.wr_en && rf.wr_num == h80_pkg::reg_flag)
            flag_q[h80_pkg::word_w-1:h80_pkg::flag_w] <=
               rf.wr_data[h80_pkg::word_w-1:h80_pkg::flag_w];
         if (rf.flag_en)
            flag_q[h80_pkg::flag_w-1:0] <= rf.flag_data;   // alu flags over move
         else if (rf.wr_en && rf.wr_num == h80_pkg::reg_flag)
            flag_q[h80_pkg::flag_w-1:0] <= rf.wr_data[h80_pkg::flag_w-1:0];
      end
   end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module h80_tb -o h80_sim
./obj_dir/h80_sim > sim.log
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
   exit 0
else
   exit 1
fi
